//--- cache_testdata.txt
# columns: op (0 load, 1 store), word address, store data, expected load value, all hex.
# the data column is unused for loads and the expected column is unused for stores.
0 00 00000000 00000000
0 13 00000000 00000000
1 05 11111111 00000000
0 05 00000000 11111111
0 04 00000000 00000000
0 06 00000000 00000000
0 07 00000000 00000000
0 05 00000000 11111111
1 06 2222aaaa 00000000
0 06 00000000 2222aaaa
0 45 00000000 00000000
0 06 00000000 2222aaaa
1 18 33330001 00000000
1 28 33330002 00000000
0 18 00000000 33330001
0 28 00000000 33330002
0 19 00000000 00000000
0 29 00000000 00000000
0 18 00000000 33330001
0 2a 00000000 00000000
0 28 00000000 33330002
0 29 00000000 00000000
0 2a 00000000 00000000
0 2b 00000000 00000000
1 2b 44440004 00000000
0 2b 00000000 44440004
0 7f 00000000 00000000
1 7c 5555cccc 00000000
0 7c 00000000 5555cccc
0 13 00000000 00000000

//--- vlog.f
+incdir+.
cache_pkg.sv
backing_memory.sv
cache_lookup.sv
cache_resolve.sv
cache_top.sv
cache_chk.sv
cache_monitor.sv
cache_tb.sv

//--- Makefile
# Verilator build and run of the cache testbench.
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/Vcache_tb

$(OBJ_DIR)/Vcache_tb: vlog.f mem_params.svh $(wildcard *.sv)
	verilator --binary --timing --assert --top-module cache_tb -Mdir $(OBJ_DIR) -f vlog.f

run: compile
	./$(OBJ_DIR)/Vcache_tb +verilator+error+limit+100 | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" sim.log || \
		(echo "simulation ended without a result line"; exit 1)

clean:
	rm -rf $(OBJ_DIR) sim.log

//--- cache_tb.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module cache_tb;

    logic                   clk;
    logic                   arst_n;
    logic                   req;
    logic                   op;
    logic [`MEM_ADDR_W-1:0] address;
    logic [`MEM_WORD_W-1:0] store_data;
    logic [`MEM_WORD_W-1:0] expected;
    logic [`MEM_WORD_W-1:0] load_data;
    logic                   load_valid;
    logic                   busy;

    int mismatch_count;
    int other_count;
    int pending;
    int file_errors;
    int missing_count;
    int assert_fails;
    int total_errors;
    int cycle_count;
    int cycle_limit;

    // one entry per operation line of the data file.
    logic                   op_q   [$];
    logic [`MEM_ADDR_W-1:0] addr_q [$];
    logic [`MEM_WORD_W-1:0] data_q [$];
    logic [`MEM_WORD_W-1:0] exp_q  [$];

    cache_top u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .op         (op),
        .address    (address),
        .store_data (store_data),
        .load_data  (load_data),
        .load_valid (load_valid),
        .busy       (busy)
    );

    cache_monitor u_mon (
        .clk            (clk),
        .arst_n         (arst_n),
        .req            (req),
        .op             (op),
        .address        (address),
        .store_data     (store_data),
        .expected       (expected),
        .load_data      (load_data),
        .load_valid     (load_valid),
        .busy           (busy),
        .mismatch_count (mismatch_count),
        .other_count    (other_count),
        .pending        (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // **************************************************
    // stimulus file and request driving.
    // **************************************************
    task automatic load_operations();
        int                     fd;
        string                  text;
        logic [`MEM_WORD_W-1:0] f_op;
        logic [`MEM_WORD_W-1:0] f_addr;
        logic [`MEM_WORD_W-1:0] f_data;
        logic [`MEM_WORD_W-1:0] f_exp;
        fd = $fopen("cache_testdata.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open cache_testdata.txt");
            file_errors++;
            return;
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;   // blank line or column notes.
            end
            if ($sscanf(text, "%h %h %h %h", f_op, f_addr, f_data, f_exp) != 4) begin
                $display("ERROR: unreadable line in cache_testdata.txt: %s", text);
                file_errors++;
                continue;
            end
            op_q.push_back(f_op[0]);
            addr_q.push_back(f_addr[`MEM_ADDR_W-1:0]);
            data_q.push_back(f_data);
            exp_q.push_back(f_exp);
        end
        $fclose(fd);
    endtask

    // called on a falling edge, returns on the falling edge after the strobe.
    task automatic drive_operation(input int i);
        while (busy) begin
            req = 1'b0;
            @(negedge clk);
        end
        req        = 1'b1;
        op         = op_q[i];
        address    = addr_q[i];
        store_data = data_q[i];
        expected   = exp_q[i];
        @(negedge clk);
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (pending != 0 && waited < 2 * (`MEM_LATENCY + 10)) begin
            @(posedge clk);
            waited++;
        end
        missing_count = pending;
        if (missing_count != 0) begin
            $display("ERROR: %0d load(s) never returned data", missing_count);
        end
    endtask

    initial begin
        req         = 1'b0;
        op          = 1'b0;
        address     = '0;
        store_data  = '0;
        expected    = '0;
        arst_n      = 1'b0;
        file_errors = 0;
        load_operations();
        if (op_q.size() == 0) begin
            $display("ERROR: no operations were read from the data file");
            file_errors++;
        end
        cycle_limit = op_q.size() * (`MEM_LATENCY + 10) + 50;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            drive_operation(i);
        end
        req = 1'b0;
        @(posedge clk);
        drain_responses();
        assert_fails = u_dut.u_chk.busy_fails + u_dut.u_chk.fill_fails
                     + u_dut.u_chk.valid_fails;
        total_errors = mismatch_count + other_count + missing_count + file_errors + assert_fails;
        $display("errors: %0d mismatch, %0d missing, %0d other, %0d file, %0d assertion",
                 mismatch_count, missing_count, other_count, file_errors, assert_fails);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // the limit is set once the data file has been read.
    initial begin
        cycle_count = 0;
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- cache_monitor.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module cache_monitor (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req,
    input  logic                   op,
    input  logic [`MEM_ADDR_W-1:0] address,
    input  logic [`MEM_WORD_W-1:0] store_data,
    input  logic [`MEM_WORD_W-1:0] expected,
    input  logic [`MEM_WORD_W-1:0] load_data,
    input  logic                   load_valid,
    input  logic                   busy,
    output int                     mismatch_count,
    output int                     other_count,
    output int                     pending
);

    logic [`MEM_WORD_W-1:0] model [`MEM_WORDS];   // write-through keeps this equal to memory.
    logic [`MEM_WORD_W-1:0] expect_q [$];
    logic [`MEM_ADDR_W-1:0] addr_q [$];

    logic                   seen_req;
    logic                   seen_op;
    logic [`MEM_ADDR_W-1:0] seen_addr;
    logic [`MEM_WORD_W-1:0] seen_data;
    logic [`MEM_WORD_W-1:0] seen_exp;
    logic                   busy_seen;   // busy at the previous falling edge.

    // requests are stable at the rising edge, outputs at the falling edge.
    always @(posedge clk) begin
        seen_req  <= req;
        seen_op   <= op;
        seen_addr <= address;
        seen_data <= store_data;
        seen_exp  <= expected;
    end

    task automatic check_response();
        logic [`MEM_WORD_W-1:0] want;
        logic [`MEM_ADDR_W-1:0] addr;
        if (expect_q.size() == 0) begin
            $display("ERROR: load_valid pulsed while no load was waiting");
            other_count++;
        end else begin
            want = expect_q.pop_front();
            addr = addr_q.pop_front();
            if (load_data !== want) begin
                $display("MISMATCH load_data at address %h: got %h expected %h",
                         addr, load_data, want);
                mismatch_count++;
            end
        end
    endtask

    task automatic record_request();
        if (seen_op == cache_pkg::OP_STORE) begin
            model[seen_addr] = seen_data;
        end else begin
            if (seen_exp !== model[seen_addr]) begin
                $display("ERROR: data file expects %h at address %h but the model holds %h",
                         seen_exp, seen_addr, model[seen_addr]);
                other_count++;
            end
            expect_q.push_back(model[seen_addr]);
            addr_q.push_back(seen_addr);
        end
    endtask

    // busy covers a refill only, and it drops as the missed word comes back.
    task automatic check_busy();
        if (busy && expect_q.size() == 0) begin
            $display("MISMATCH busy with no load waiting: got %h expected %h", busy, 1'b0);
            mismatch_count++;
        end
        if (busy_seen && !busy && !load_valid) begin
            $display("MISMATCH load_valid as busy fell: got %h expected %h", load_valid, 1'b1);
            mismatch_count++;
        end
        busy_seen = busy;
    endtask

    always @(negedge clk or negedge arst_n) begin
        if (!arst_n) begin
            foreach (model[a]) begin
                model[a] = '0;   // memory clears on reset.
            end
            expect_q.delete();
            addr_q.delete();
            mismatch_count = 0;
            other_count    = 0;
            busy_seen      = 1'b0;
        end else begin
            if (load_valid) begin
                check_response();
            end
            if (seen_req) begin
                record_request();
            end
            check_busy();
        end
        pending = expect_q.size();
    end

endmodule

//--- cache_chk.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module cache_chk (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 req,
    input logic                 op,
    input logic                 busy,
    input logic                 load_valid,
    input cache_pkg::fill_req_t fill_req,
    input cache_pkg::fill_rsp_t fill_rsp
);

    int loads_open;          // loads issued and not yet answered.
    int busy_fails  = 0;
    int fill_fails  = 0;
    int valid_fails = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            loads_open <= 0;
        end else begin
            loads_open <= loads_open
                + ((req && (op == cache_pkg::OP_LOAD)) ? 1 : 0)
                - (load_valid ? 1 : 0);
        end
    end

    // **************************************************
    // protocol properties.
    // **************************************************
    a_no_req_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
        !(req && busy))
        else begin
            $error("request issued while the cache was busy");
            busy_fails++;
        end

    // a line read must come back after exactly the memory latency.
    a_fill_answered: assert property (@(posedge clk) disable iff (!arst_n)
        (fill_req.valid && !fill_req.store) |-> ##(`MEM_LATENCY) fill_rsp.valid)
        else begin
            $error("line read got no response after the memory latency");
            fill_fails++;
        end

    a_load_valid_owned: assert property (@(posedge clk) disable iff (!arst_n)
        load_valid |-> (loads_open > 0))
        else begin
            $error("load_valid pulsed with no load outstanding");
            valid_fails++;
        end

endmodule

bind cache_top cache_chk u_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .op         (op),
    .busy       (busy),
    .load_valid (load_valid),
    .fill_req   (fill_req),
    .fill_rsp   (fill_rsp)
);

//--- cache_top.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module cache_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req,
    input  logic                   op,
    input  logic [`MEM_ADDR_W-1:0] address,
    input  logic [`MEM_WORD_W-1:0] store_data,
    output logic [`MEM_WORD_W-1:0] load_data,
    output logic                   load_valid,
    output logic                   busy
);

    cache_pkg::cpu_req_t     cpu_req;
    cache_pkg::lookup_t      stage;
    cache_pkg::fill_req_t    fill_req;
    cache_pkg::fill_rsp_t    fill_rsp;
    logic                    tag_we;
    logic [`CACHE_IDX_W-1:0] tag_index;
    logic [`CACHE_TAG_W-1:0] tag_value;

    // the CPU strobe becomes the valid bit of the request.
    assign cpu_req = '{
        valid: req,
        op:    cache_pkg::mem_op_e'(op),
        addr:  address,
        data:  store_data
    };

    cache_lookup u_lookup (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .tag_we    (tag_we),
        .tag_index (tag_index),
        .tag_value (tag_value),
        .stall     (busy),
        .stage_out (stage)
    );

    cache_resolve u_resolve (
        .clk        (clk),
        .arst_n     (arst_n),
        .stage_in   (stage),
        .fill_rsp   (fill_rsp),
        .fill_req   (fill_req),
        .tag_we     (tag_we),
        .tag_index  (tag_index),
        .tag_value  (tag_value),
        .stall      (busy),          // refill stall doubles as CPU busy.
        .load_data  (load_data),
        .load_valid (load_valid)
    );

    backing_memory u_memory (
        .clk      (clk),
        .arst_n   (arst_n),
        .fill_req (fill_req),
        .fill_rsp (fill_rsp)
    );

endmodule

//--- cache_resolve.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module cache_resolve (
    input  logic                    clk,
    input  logic                    arst_n,
    input  cache_pkg::lookup_t      stage_in,
    input  cache_pkg::fill_rsp_t    fill_rsp,
    output cache_pkg::fill_req_t    fill_req,
    output logic                    tag_we,
    output logic [`CACHE_IDX_W-1:0] tag_index,
    output logic [`CACHE_TAG_W-1:0] tag_value,
    output logic                    stall,
    output logic [`MEM_WORD_W-1:0]  load_data,
    output logic                    load_valid
);

    cache_pkg::resolve_state_e state;
    cache_pkg::resolve_state_e state_next;

    logic [`LINE_WORDS-1:0][`MEM_WORD_W-1:0] data_array [`CACHE_LINES];
    logic [`LINE_WORDS-1:0][`MEM_WORD_W-1:0] fill_line;   // line held from the response.
    logic [`MEM_ADDR_W-1:0]                  miss_addr;

    logic [`CACHE_IDX_W-1:0] idx;
    logic [`CACHE_OFF_W-1:0] word_sel;
    logic [`CACHE_OFF_W-1:0] miss_word;
    logic                    accept;
    logic                    is_load;
    logic                    is_store;
    logic                    load_hit;
    logic                    load_miss;
    logic                    fill_done;

    assign idx      = stage_in.req.addr[`CACHE_OFF_W +: `CACHE_IDX_W];
    assign word_sel = stage_in.req.addr[`CACHE_OFF_W-1:0];

    // requests are only taken while no refill is running.
    assign accept    = (state == cache_pkg::IDLE) && stage_in.req.valid;
    assign is_load   = accept && (stage_in.req.op == cache_pkg::OP_LOAD);
    assign is_store  = accept && (stage_in.req.op == cache_pkg::OP_STORE);
    assign load_hit  = is_load && stage_in.hit;
    assign load_miss = is_load && !stage_in.hit;
    assign fill_done = (state == cache_pkg::FILL_WAIT) && fill_rsp.valid;

    assign miss_word = miss_addr[`CACHE_OFF_W-1:0];
    assign stall     = (state != cache_pkg::IDLE);
    assign tag_we    = (state == cache_pkg::FILL_WRITE);
    assign tag_index = miss_addr[`CACHE_OFF_W +: `CACHE_IDX_W];
    assign tag_value = miss_addr[`MEM_ADDR_W-1 -: `CACHE_TAG_W];

    // **************************************************
    // refill FSM.
    // **************************************************
    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::IDLE: begin
                if (load_miss) begin
                    state_next = cache_pkg::FILL_WAIT;
                end
            end
            cache_pkg::FILL_WAIT: begin
                if (fill_rsp.valid) begin
                    state_next = cache_pkg::FILL_WRITE;
                end
            end
            cache_pkg::FILL_WRITE: state_next = cache_pkg::IDLE;
            default:               state_next = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= cache_pkg::IDLE;
            fill_req   <= '0;
            load_valid <= 1'b0;
        end else begin
            state          <= state_next;
            // every store goes to memory, a miss asks for its line.
            fill_req.valid <= is_store || load_miss;
            fill_req.store <= is_store;
            fill_req.addr  <= stage_in.req.addr;
            fill_req.data  <= stage_in.req.data;
            load_valid     <= load_hit || tag_we;
        end
    end

    // **************************************************
    // data array and returned word.
    // **************************************************
    always_ff @(posedge clk) begin
        if (load_miss) begin
            miss_addr <= stage_in.req.addr;
        end
        if (fill_done) begin
            fill_line <= fill_rsp.line;
        end
        if (is_store && stage_in.hit) begin
            data_array[idx][word_sel] <= stage_in.req.data;   // write-through update.
        end
        if (tag_we) begin
            data_array[tag_index] <= fill_line;
        end
        if (load_hit) begin
            load_data <= data_array[idx][word_sel];
        end else if (tag_we) begin
            load_data <= fill_line[miss_word];
        end
    end

endmodule

//--- cache_lookup.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module cache_lookup (
    input  logic                    clk,
    input  logic                    arst_n,
    input  cache_pkg::cpu_req_t     cpu_req,
    input  logic                    tag_we,
    input  logic [`CACHE_IDX_W-1:0] tag_index,
    input  logic [`CACHE_TAG_W-1:0] tag_value,
    input  logic                    stall,
    output cache_pkg::lookup_t      stage_out
);

    logic [`CACHE_TAG_W-1:0] tag_array [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_bits;

    cache_pkg::cpu_req_t     eval_req;
    logic [`CACHE_IDX_W-1:0] idx;
    logic [`CACHE_TAG_W-1:0] tag;
    logic                    hit;

    // while stalled the held request is checked again each cycle.
    // a fill may replace its line before the resolve stage takes it.
    assign eval_req = stall ? stage_out.req : cpu_req;

    assign idx = eval_req.addr[`CACHE_OFF_W +: `CACHE_IDX_W];
    assign tag = eval_req.addr[`MEM_ADDR_W-1 -: `CACHE_TAG_W];

    // **************************************************
    // tag compare.
    // **************************************************
    always_comb begin
        if (tag_we && (tag_index == idx)) begin
            hit = (tag_value == tag);   // the tag being written wins.
        end else begin
            hit = valid_bits[idx] && (tag_array[idx] == tag);
        end
    end

    // **************************************************
    // stage register and valid bits.
    // **************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_out  <= '0;
            valid_bits <= '0;
        end else begin
            stage_out.req <= eval_req;
            stage_out.hit <= hit;
            if (tag_we) begin
                valid_bits[tag_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_array[tag_index] <= tag_value;
        end
    end

endmodule

//--- backing_memory.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module backing_memory (
    input  logic                 clk,
    input  logic                 arst_n,
    input  cache_pkg::fill_req_t fill_req,
    output cache_pkg::fill_rsp_t fill_rsp
);

    logic [`MEM_WORDS-1:0][`MEM_WORD_W-1:0]  storage;
    logic [`LINE_WORDS-1:0][`MEM_WORD_W-1:0] line_words;
    logic [`MEM_ADDR_W-`CACHE_OFF_W-1:0]     line_sel;
    logic                                    read_strobe;
    logic                                    write_strobe;

    // responses travel through this pipe so several reads can be in flight.
    cache_pkg::fill_rsp_t [`MEM_LATENCY-1:0] delay_pipe;

    assign line_sel     = fill_req.addr[`MEM_ADDR_W-1:`CACHE_OFF_W];
    assign read_strobe  = fill_req.valid & ~fill_req.store;
    assign write_strobe = fill_req.valid & fill_req.store;

    // **************************************************
    // line assembly.
    // **************************************************
    // word 0 of the line sits in the lowest bits.
    always_comb begin
        for (int w = 0; w < `LINE_WORDS; w++) begin
            line_words[w] = storage[{line_sel, w[`CACHE_OFF_W-1:0]}];
        end
    end

    // **************************************************
    // storage and response delay.
    // **************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            storage    <= '0;
            delay_pipe <= '0;
        end else begin
            if (write_strobe) begin
                storage[fill_req.addr] <= fill_req.data;
            end
            delay_pipe[0] <= '{valid: read_strobe, line: line_words};
            for (int s = 1; s < `MEM_LATENCY; s++) begin
                delay_pipe[s] <= delay_pipe[s-1];
            end
        end
    end

    assign fill_rsp = delay_pipe[`MEM_LATENCY-1];   // valid pulses one cycle per read.

endmodule

//--- cache_pkg.sv
`include "mem_params.svh"

package cache_pkg;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    // request from the CPU side as it enters the lookup stage.
    typedef struct packed {
        logic                   valid;
        mem_op_e                op;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_WORD_W-1:0] data;
    } cpu_req_t;

    typedef struct packed {
        cpu_req_t req;
        logic     hit;   // tag matched at lookup time.
    } lookup_t;

    typedef struct packed {
        logic                   valid;
        logic                   store;   // a clear bit launches a line read.
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_WORD_W-1:0] data;
    } fill_req_t;

    typedef struct packed {
        logic                   valid;
        logic [`MEM_LINE_W-1:0] line;
    } fill_rsp_t;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        FILL_WAIT  = 2'd1,
        FILL_WRITE = 2'd2
    } resolve_state_e;

endpackage

//--- mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// **************************************************
// backing memory geometry and timing.
// **************************************************
`define MEM_WORD_W   32    // one storage word.
`define MEM_LINE_W   128   // one fill line.
`define MEM_WORDS    128
`define MEM_ADDR_W   7     // word address width.
`define MEM_LATENCY  5     // cycles from line read strobe to response.

// **************************************************
// cache geometry.
// **************************************************
`define CACHE_LINES  4
`define LINE_WORDS   4     // words per line.
`define CACHE_OFF_W  2     // address bits 1 to 0 select the word.
`define CACHE_IDX_W  2     // address bits 3 to 2 select the line.
`define CACHE_TAG_W  3     // address bits 6 to 4 form the tag.

`endif
